//--- src/clk_ctrl_pkg.sv
/*
 * Shared definitions for the clock-control block.
 * All logic runs on sys_clk_i; the divide values are 8 bits wide and only
 * the low 12 address bits reach the block.
 * The request struct follows the legacy access style: sel and en rise
 * together and stay up until pready has been seen.
 */
`default_nettype none

package clk_ctrl_pkg;

    // divide value and register offset widths
    localparam int DIV_W  = 8;
    localparam int ADDR_W = 12;

    // register map, one 8-bit divide value per branch
    localparam logic [ADDR_W-1:0] SOC_DIV_OFFS     = 12'hF00;
    localparam logic [ADDR_W-1:0] CLUSTER_DIV_OFFS = 12'hF08;
    localparam logic [ADDR_W-1:0] PERIPH_DIV_OFFS  = 12'hF10;

    // soc, cluster and periph branches
    localparam int NUM_DIV = 3;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_READY  = 2'd2
    } access_state_e;

    // request as driven by the bus master
    typedef struct packed {
        logic              sel;
        logic              en;
        access_op_e        op;
        logic [ADDR_W-1:0] addr;
        logic [DIV_W-1:0]  wdata;
    } cfg_bus_req_t;

    // captured command, valid for a single cycle
    typedef struct packed {
        logic              valid;
        access_op_e        op;
        logic [ADDR_W-1:0] addr;
        logic [DIV_W-1:0]  wdata;
    } cfg_cmd_t;

    // current divide values of the three programmable branches
    typedef struct packed {
        logic [DIV_W-1:0] soc;
        logic [DIV_W-1:0] cluster;
        logic [DIV_W-1:0] periph;
    } div_vals_t;

endpackage

`default_nettype wire

//--- src/cfg_access_fsm.sv
/*
 * Bus access state machine.
 * Samples a request when sel and en are both high in idle, issues the
 * captured command for one cycle and pulses pready one cycle later.
 * Fixed latency of two cycles from the sampling edge, no back-pressure.
 * The master must drop sel/en in the cycle after pready, otherwise a
 * second access starts.
 */
`timescale 1ns/10ps
`default_nettype none

module cfg_access_fsm import clk_ctrl_pkg::*; (
    input  wire logic         sys_clk_i,
    input  wire logic         rstn_glob_i,
    input  wire cfg_bus_req_t bus_req_i,
    output cfg_cmd_t          cmd_o,
    output logic              pready_o
);

    access_state_e state_q;
    access_state_e state_d;

    // request seen while idle
    logic req_start;

    // captured payload of the current access
    access_op_e        op_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DIV_W-1:0]  wdata_q;

    // penable rises together with psel, so both are tested at once
    assign req_start = bus_req_i.sel && bus_req_i.en && (state_q == ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_start) begin
                    state_d = ST_ACCESS;
                end
            end
            // command goes out to the register file in this state
            ST_ACCESS: begin
                state_d = ST_READY;
            end
            // read data is registered by now, pready for one cycle
            ST_READY: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk_i or negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload only, held until the next access is sampled
    always_ff @(posedge sys_clk_i) begin
        if (req_start) begin
            op_q    <= bus_req_i.op;
            addr_q  <= bus_req_i.addr;
            wdata_q <= bus_req_i.wdata;
        end
    end

    // one-cycle command towards the register file
    assign cmd_o.valid = (state_q == ST_ACCESS);
    assign cmd_o.op    = op_q;
    assign cmd_o.addr  = addr_q;
    assign cmd_o.wdata = wdata_q;

    // access completes here, prdata is valid in the same cycle
    assign pready_o = (state_q == ST_READY);

endmodule

`default_nettype wire

//--- src/div_reg_file.sv
/*
 * Divide-value registers with address decode and read mux.
 * Writes to unmapped offsets are accepted and dropped; reads of unmapped
 * offsets return zero. All values reset to 0, which puts every branch in
 * bypass. reload_o bit 0 is soc, bit 1 cluster, bit 2 periph.
 */
`timescale 1ns/10ps
`default_nettype none

module div_reg_file import clk_ctrl_pkg::*; (
    input  wire logic         sys_clk_i,
    input  wire logic         rstn_glob_i,
    input  wire cfg_cmd_t     cmd_i,
    output logic [DIV_W-1:0]  rdata_o,
    output div_vals_t         div_vals_o,
    output logic [NUM_DIV-1:0] reload_o
);

    // one-hot offset decode
    logic [NUM_DIV-1:0] hit;
    logic               wr_en;
    logic               rd_en;
    logic [DIV_W-1:0]   rd_val;
    div_vals_t          vals_q;

    always_comb begin
        hit = '0;
        case (cmd_i.addr)
            SOC_DIV_OFFS:     hit[0] = 1'b1;
            CLUSTER_DIV_OFFS: hit[1] = 1'b1;
            PERIPH_DIV_OFFS:  hit[2] = 1'b1;
            // anything else is a silent dummy access
            default:          hit    = '0;
        endcase
    end

    assign wr_en = cmd_i.valid && (cmd_i.op == OP_WRITE);
    assign rd_en = cmd_i.valid && (cmd_i.op == OP_READ);

    // read mux, zero for unmapped offsets
    always_comb begin
        rd_val = '0;
        if (hit[0]) begin
            rd_val = vals_q.soc;
        end else if (hit[1]) begin
            rd_val = vals_q.cluster;
        end else if (hit[2]) begin
            rd_val = vals_q.periph;
        end
    end

    always_ff @(posedge sys_clk_i or negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            vals_q   <= '0;
            reload_o <= '0;
            rdata_o  <= '0;
        end else begin
            // strobe only for the branch actually written
            reload_o <= hit & {NUM_DIV{wr_en}};
            if (wr_en && hit[0]) begin
                vals_q.soc <= cmd_i.wdata;
            end
            if (wr_en && hit[1]) begin
                vals_q.cluster <= cmd_i.wdata;
            end
            if (wr_en && hit[2]) begin
                vals_q.periph <= cmd_i.wdata;
            end
            // rdata holds its value between reads
            if (rd_en) begin
                rdata_o <= rd_val;
            end
        end
    end

    assign div_vals_o = vals_q;

endmodule

`default_nettype wire

//--- src/tick_divider.sv
/*
 * Tick divider producing a one-cycle enable strobe on sys_clk_i.
 * Programmable mode: period N from div_i, values 0 and 1 tick every cycle.
 * A reload restarts the count so that the first tick is high in the Nth
 * cycle after the edge that loaded the new value.
 * Fixed mode: counts FIXED_RATIO (>= 2) from reset release and ignores
 * div_i and reload_i.
 */
`timescale 1ns/10ps
`default_nettype none

module tick_divider import clk_ctrl_pkg::*; #(
    parameter bit FIXED       = 1'b0,
    parameter int FIXED_RATIO = 2
) (
    input  wire logic             sys_clk_i,
    input  wire logic             rstn_glob_i,
    input  wire logic [DIV_W-1:0] div_i,
    input  wire logic             reload_i,
    output logic                  tick_o
);

    // fixed ratio may need more bits than a divide value
    localparam int CNT_W = FIXED ? $clog2(FIXED_RATIO) : DIV_W;
    // fixed mode starts its first period at reset release
    localparam logic [CNT_W-1:0] CNT_INIT = FIXED ? CNT_W'(FIXED_RATIO - 1) : '0;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] period_m1;
    logic             bypass;
    logic             restart;
    logic             tick_q;

    if (FIXED) begin : g_fixed
        assign period_m1 = CNT_W'(FIXED_RATIO - 1);
        assign bypass    = 1'b0;
        assign restart   = 1'b0;
    end else begin : g_prog
        assign period_m1 = div_i - 1'b1;
        // 0 and 1 both mean undivided
        assign bypass    = (div_i <= DIV_W'(1));
        assign restart   = reload_i;
    end

    always_ff @(posedge sys_clk_i or negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            cnt_q  <= CNT_INIT;
            tick_q <= 1'b0;
        end else if (bypass) begin
            cnt_q  <= '0;
            tick_q <= 1'b1;
        end else if (restart) begin
            // the reload edge itself counts as one cycle of the period
            cnt_q  <= period_m1 - 1'b1;
            tick_q <= 1'b0;
        end else if (cnt_q == '0) begin
            // terminal count, tick and start over
            cnt_q  <= period_m1;
            tick_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_q <= 1'b0;
        end
    end

    assign tick_o = tick_q;

endmodule

`default_nettype wire

//--- src/clk_ctrl_top.sv
/*
 * Clock-control top level, single sys_clk_i domain.
 * Divided branches are delivered as one-cycle enable ticks, not as clocks.
 * Registers at F00 (soc), F08 (cluster) and F10 (periph) hold 8-bit divide
 * values; every access completes with pready two cycles after sampling.
 * SLOW_RATIO sets the fixed timer tick period and must be at least 2.
 */
`timescale 1ns/10ps
`default_nettype none

module clk_ctrl_top import clk_ctrl_pkg::*; #(
    parameter int SLOW_RATIO = 3125
) (
    input  wire logic         sys_clk_i,
    input  wire logic         rstn_glob_i,
    input  wire cfg_bus_req_t bus_req_i,
    output logic [DIV_W-1:0]  prdata_o,
    output logic              pready_o,
    output logic              soc_tick_o,
    output logic              cluster_tick_o,
    output logic              periph_tick_o,
    output logic              slow_tick_o
);

    cfg_cmd_t           cmd;
    div_vals_t          div_vals;
    logic [NUM_DIV-1:0] reload;

    // bus side, captures the request and times pready
    cfg_access_fsm i_cfg_access_fsm (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .bus_req_i   (bus_req_i),
        .cmd_o       (cmd),
        .pready_o    (pready_o)
    );

    // divide values and read data
    div_reg_file i_div_reg_file (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .cmd_i       (cmd),
        .rdata_o     (prdata_o),
        .div_vals_o  (div_vals),
        .reload_o    (reload)
    );

    // soc branch
    tick_divider i_soc_div (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_i       (div_vals.soc),
        .reload_i    (reload[0]),
        .tick_o      (soc_tick_o)
    );

    // cluster branch
    tick_divider i_cluster_div (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_i       (div_vals.cluster),
        .reload_i    (reload[1]),
        .tick_o      (cluster_tick_o)
    );

    // peripheral branch, same clock as the others
    tick_divider i_periph_div (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_i       (div_vals.periph),
        .reload_i    (reload[2]),
        .tick_o      (periph_tick_o)
    );

    // slow timer tick, fixed ratio, no register behind it
    tick_divider #(
        .FIXED       (1'b1),
        .FIXED_RATIO (SLOW_RATIO)
    ) i_slow_div (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_i       ('0),
        .reload_i    (1'b0),
        .tick_o      (slow_tick_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_ctrl_model.svh
/*
 * Reference model of the clock-control block, included inside tb_clk_ctrl.
 * Needs SLOW_RATIO and the package names in scope where it is included.
 * Mirrors the three divide registers, counts rising edges since each
 * reload and predicts every tick from that count alone.
 */
`ifndef TB_CLK_CTRL_MODEL_SVH
`define TB_CLK_CTRL_MODEL_SVH

// mirrored divide values, index 0 soc, 1 cluster, 2 periph
int unsigned div_val [NUM_DIV];
// rising edges since the last reload of each branch
int unsigned div_cycles [NUM_DIV];
// rising edges since reset release
int unsigned slow_cycles;

function automatic int offs_to_index(input logic [ADDR_W-1:0] addr);
    case (addr)
        SOC_DIV_OFFS:     return 0;
        CLUSTER_DIV_OFFS: return 1;
        PERIPH_DIV_OFFS:  return 2;
        default:          return -1;
    endcase
endfunction

// unmapped offsets read back as zero
function automatic logic [DIV_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    int idx;
    idx = offs_to_index(addr);
    if (idx < 0) begin
        return '0;
    end
    return DIV_W'(div_val[idx]);
endfunction

// a mapped write restarts the count of that branch only
task automatic apply_write(input logic [ADDR_W-1:0] addr, input logic [DIV_W-1:0] data);
    int idx;
    idx = offs_to_index(addr);
    if (idx >= 0) begin
        div_val[idx]    = data;
        div_cycles[idx] = 0;
    end
endtask

task automatic clear_model();
    for (int i = 0; i < NUM_DIV; i++) begin
        div_val[i]    = 0;
        div_cycles[i] = 0;
    end
    slow_cycles = 0;
endtask

// one rising edge, tick when N edges have passed or in bypass
task automatic advance_ticks(output logic [NUM_DIV-1:0] ticks, output logic slow);
    for (int i = 0; i < NUM_DIV; i++) begin
        div_cycles[i]++;
        ticks[i] = (div_val[i] <= 1) || (div_cycles[i] % div_val[i] == 0);
    end
    slow_cycles++;
    slow = (slow_cycles % SLOW_RATIO == 0);
endtask

`endif

//--- verif/tb_clk_ctrl.sv
/*
 * Testbench for clk_ctrl_top with SLOW_RATIO = 10.
 * Inputs change on the falling edge, outputs are checked on the falling
 * edge against the included model. Bus accesses are one at a time and
 * drop sel/en as soon as pready is seen. Random traffic uses a fixed seed.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_ctrl import clk_ctrl_pkg::*; ();

    localparam int SLOW_RATIO   = 10;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 2;
    // access counts of the test phases
    localparam int WR_ROUNDS    = 12;
    localparam int UNMAP_WRITES = 8;
    localparam int UNMAP_READS  = 4;
    localparam int TICK_WRITES  = 4 * NUM_DIV;
    localparam int NUM_ACCESSES = NUM_DIV + 2 * WR_ROUNDS + UNMAP_WRITES + NUM_DIV
                                + UNMAP_READS + TICK_WRITES;
    localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 40 + 2000;

    logic             sys_clk;
    logic             rstn_glob;
    cfg_bus_req_t     bus_req;
    logic [DIV_W-1:0] prdata;
    logic             pready;
    logic             soc_tick;
    logic             cluster_tick;
    logic             periph_tick;
    logic             slow_tick;

    `include "tb_clk_ctrl_model.svh"

    // bus side of the model, mirrors the access FSM
    access_state_e      exp_state;
    access_op_e         exp_op;
    logic [ADDR_W-1:0]  exp_addr;
    logic [DIV_W-1:0]   exp_wdata;
    logic               exp_pready;
    logic [NUM_DIV-1:0] exp_ticks;
    logic               exp_slow;
    logic               model_valid = 1'b0;
    int unsigned        cycle_count = 0;

    clk_ctrl_top #(
        .SLOW_RATIO (SLOW_RATIO)
    ) uut (
        .sys_clk_i      (sys_clk),
        .rstn_glob_i    (rstn_glob),
        .bus_req_i      (bus_req),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .soc_tick_o     (soc_tick),
        .cluster_tick_o (cluster_tick),
        .periph_tick_o  (periph_tick),
        .slow_tick_o    (slow_tick)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) @(negedge sys_clk);
    endtask

    // one access, pready must come on the second falling edge
    task automatic bus_access(input access_op_e op, input logic [ADDR_W-1:0] addr,
                              input logic [DIV_W-1:0] wdata, output logic [DIV_W-1:0] rdata);
        int waited;
        waited = 0;
        @(negedge sys_clk);
        bus_req.sel   = 1'b1;
        bus_req.en    = 1'b1;
        bus_req.op    = op;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        do begin
            @(negedge sys_clk);
            waited++;
        end while (!pready);
        check_value("pready_o latency", 2, waited);
        rdata       = prdata;
        bus_req.sel = 1'b0;
        bus_req.en  = 1'b0;
        idle_cycles($urandom_range(0, 3));
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DIV_W-1:0] data);
        logic [DIV_W-1:0] unused_rd;
        bus_access(OP_WRITE, addr, data, unused_rd);
    endtask

    // read back and compare with the mirrored register
    task automatic read_reg(input logic [ADDR_W-1:0] addr);
        logic [DIV_W-1:0] rd;
        bus_access(OP_READ, addr, DIV_W'($urandom), rd);
        check_value("prdata_o", expected_read(addr), rd);
    endtask

    function automatic logic [ADDR_W-1:0] index_to_offs(input int unsigned idx);
        case (idx)
            0:       return SOC_DIV_OFFS;
            1:       return CLUSTER_DIV_OFFS;
            default: return PERIPH_DIV_OFFS;
        endcase
    endfunction

    // half of the misses land close to the register block
    function automatic logic [ADDR_W-1:0] random_unmapped_addr();
        logic [ADDR_W-1:0] a;
        do begin
            a = ($urandom_range(0, 1) == 1) ? (12'hF00 + ADDR_W'($urandom_range(0, 31)))
                                            : ADDR_W'($urandom);
        end while (offs_to_index(a) >= 0);
        return a;
    endfunction

    // model advances on the rising edge, bus inputs are stable there
    always @(posedge sys_clk) begin
        if (!rstn_glob) begin
            clear_model();
            exp_state   = ST_IDLE;
            exp_pready  = 1'b0;
            exp_ticks   = '0;
            exp_slow    = 1'b0;
            model_valid = 1'b0;
        end else begin
            advance_ticks(exp_ticks, exp_slow);
            model_valid = 1'b1;
            case (exp_state)
                ST_IDLE: begin
                    exp_pready = 1'b0;
                    if (bus_req.sel && bus_req.en) begin
                        exp_op    = bus_req.op;
                        exp_addr  = bus_req.addr;
                        exp_wdata = bus_req.wdata;
                        exp_state = ST_ACCESS;
                    end
                end
                // register and reload update one edge after sampling
                ST_ACCESS: begin
                    if (exp_op == OP_WRITE) begin
                        apply_write(exp_addr, exp_wdata);
                    end
                    exp_pready = 1'b1;
                    exp_state  = ST_READY;
                end
                default: begin
                    exp_pready = 1'b0;
                    exp_state  = ST_IDLE;
                end
            endcase
        end
    end

    // every output checked mid-cycle
    // reset values only once a rising edge has passed
    always @(negedge sys_clk) begin
        if (!rstn_glob && cycle_count > 0) begin
            check_value("pready_o", 0, pready);
            check_value("prdata_o", 0, prdata);
            check_value("soc_tick_o", 0, soc_tick);
            check_value("cluster_tick_o", 0, cluster_tick);
            check_value("periph_tick_o", 0, periph_tick);
            check_value("slow_tick_o", 0, slow_tick);
        end else if (model_valid) begin
            check_value("pready_o", exp_pready, pready);
            check_value("soc_tick_o", exp_ticks[0], soc_tick);
            check_value("cluster_tick_o", exp_ticks[1], cluster_tick);
            check_value("periph_tick_o", exp_ticks[2], periph_tick);
            check_value("slow_tick_o", exp_slow, slow_tick);
        end
    end

    always @(posedge sys_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int unsigned idx;
        int unsigned n;
        void'($urandom(32'he653ffed));
        rstn_glob = 1'b0;
        bus_req   = '0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        rstn_glob = 1'b1;

        // all branches in bypass, registers read as zero
        idle_cycles(10);
        for (int i = 0; i < NUM_DIV; i++) begin
            read_reg(index_to_offs(i));
        end

        // random writes, each followed by a read of some register
        for (int i = 0; i < WR_ROUNDS; i++) begin
            idx = $urandom_range(0, NUM_DIV - 1);
            write_reg(index_to_offs(idx), DIV_W'($urandom));
            idx = $urandom_range(0, NUM_DIV - 1);
            read_reg(index_to_offs(idx));
        end

        // misses leave the mapped registers and the ticks alone
        for (int i = 0; i < UNMAP_WRITES; i++) begin
            write_reg(random_unmapped_addr(), DIV_W'($urandom));
        end
        for (int i = 0; i < NUM_DIV; i++) begin
            read_reg(index_to_offs(i));
        end
        for (int i = 0; i < UNMAP_READS; i++) begin
            read_reg(random_unmapped_addr());
        end

        // bypass values, then one long and one short random period
        for (int d = 0; d < NUM_DIV; d++) begin
            write_reg(index_to_offs(d), 8'd0);
            idle_cycles(6);
            write_reg(index_to_offs(d), 8'd1);
            idle_cycles(6);
            n = $urandom_range(2, 255);
            write_reg(index_to_offs(d), DIV_W'(n));
            idle_cycles(2 * n + 4);
            n = $urandom_range(2, 40);
            write_reg(index_to_offs(d), DIV_W'(n));
            idle_cycles(2 * n + 4);
        end

        // a few more slow periods with a quiet bus
        idle_cycles(2 * SLOW_RATIO);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verif
src/clk_ctrl_pkg.sv
src/cfg_access_fsm.sv
src/div_reg_file.sv
src/tick_divider.sv
src/clk_ctrl_top.sv
verif/tb_clk_ctrl.sv

//--- Makefile
# Verilator build and run of the clock-control testbench
TOP := tb_clk_ctrl
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
